// File: sources.f
aluPkg.sv
integerLogicUnit.sv
intSqrtUnit.sv
aluSequencer.sv
alu.sv
aluTb.sv

// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module aluTb -f sources.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/ValuTb > sim.log 2>&1

grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }

// File: aluTb.sv
`default_nettype none

module aluTb import aluPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DataWidth = 32;
    localparam int OpTimeout = 64;
    localparam int RandomOps = 400;
    localparam logic [DataWidth-1:0] MinValue = {1'b1, {(DataWidth - 1){1'b0}}};

    logic                 Clock;
    logic                 Reset;
    logic                 start;
    logic [DataWidth-1:0] operandA;
    logic [DataWidth-1:0] operandB;
    logic [5:0]           functionCode;
    logic                 done;
    logic [DataWidth-1:0] result;

    logic [DataWidth-1:0] lastResult;
    logic [5:0]           randomCodes [0:19];
    integer               seed;

    alu #(.DataWidth(DataWidth)) i_alu (
        .Clock        (Clock),
        .Reset        (Reset),
        .start        (start),
        .operandA     (operandA),
        .operandB     (operandB),
        .functionCode (functionCode),
        .done         (done),
        .result       (result)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    task automatic failTest(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Largest root whose square fits in the unsigned value
    task automatic floorSqrt(input logic [DataWidth-1:0] value, output logic [DataWidth-1:0] root);
        logic [DataWidth-1:0]   candidate;
        logic [2*DataWidth-1:0] square;
        int                     bitIndex;
        root = '0;
        for (bitIndex = DataWidth / 2 - 1; bitIndex >= 0; bitIndex--) begin
            candidate = root | (DataWidth'(1) << bitIndex);
            square = (2*DataWidth)'(candidate) * (2*DataWidth)'(candidate);
            if (square <= (2*DataWidth)'(value)) begin
                root = candidate;
            end
        end
    endtask

    task automatic computeExpected(input logic [5:0] code, input logic [DataWidth-1:0] a,
                                   input logic [DataWidth-1:0] b,
                                   output logic [DataWidth-1:0] expected);
        logic signed [DataWidth-1:0] sa;
        logic signed [DataWidth-1:0] sb;
        logic [4:0]                  amount;
        logic                        overflow;
        sa = a;
        sb = b;
        amount = b[4:0];
        overflow = (a == MinValue) && (b == '1);
        case (code)
            intAdd:             expected = a + b;
            intSub:             expected = a - b;
            intMul:             expected = sa * sb;
            intSqrt:            floorSqrt(a, expected);
            intDiv: begin
                if (b == '0) expected = '1;
                else if (overflow) expected = a;
                else expected = sa / sb;
            end
            intMod: begin
                if (b == '0) expected = a;
                else if (overflow) expected = '0;
                else expected = sa % sb;
            end
            shiftLeftArith:     expected = a << amount;
            shiftLeftLogic:     expected = a << amount;
            shiftRightArith:    expected = sa >>> amount;
            shiftRightLogic:    expected = a >> amount;
            cmpEqual:           expected = (a == b) ? 1 : 0;
            cmpNotEqual:        expected = (a != b) ? 1 : 0;
            cmpGreater:         expected = (sa > sb) ? 1 : 0;
            cmpLess:            expected = (sa < sb) ? 1 : 0;
            cmpGreaterUnsigned: expected = (a > b) ? 1 : 0;
            cmpLessUnsigned:    expected = (a < b) ? 1 : 0;
            logicNot:           expected = ~a;
            logicAnd:           expected = a & b;
            logicOr:            expected = a | b;
            logicXor:           expected = a ^ b;
            logicXnor:          expected = ~(a ^ b);
            default:            expected = '0;
        endcase
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < OpTimeout) begin
            @(negedge Clock);
            waited++;
        end
        assert (done === 1'b1) else failTest("Timed out waiting for the ALU to go idle");
    endtask

    task automatic runOp(input logic [5:0] code, input logic [DataWidth-1:0] a,
                         input logic [DataWidth-1:0] b, input logic busyStart);
        logic [DataWidth-1:0] expected;
        int                   cycles;
        computeExpected(code, a, b, expected);
        waitIdle();
        @(posedge Clock);
        start        <= 1'b1;
        functionCode <= code;
        operandA     <= a;
        operandB     <= b;
        @(posedge Clock);
        // Scramble the inputs once they are captured
        start        <= 1'b0;
        functionCode <= 6'($random(seed));
        operandA     <= $random(seed);
        operandB     <= $random(seed);
        @(negedge Clock);
        assert (done === 1'b0) else failTest("done stayed high after an accepted start");
        cycles = 0;
        while (done !== 1'b1 && cycles < OpTimeout) begin
            // Old result stays while busy
            assert (result === lastResult) else failTest($sformatf(
                "Mismatch result held got=%08h expected=%08h", result, lastResult));
            @(posedge Clock);
            cycles++;
            if (busyStart && cycles == 3) begin
                // A start while busy must be ignored
                start        <= 1'b1;
                functionCode <= intAdd;
                operandA     <= $random(seed);
                operandB     <= $random(seed);
            end else begin
                start <= 1'b0;
            end
            @(negedge Clock);
        end
        assert (done === 1'b1) else failTest("Timed out waiting for done after a start");
        if (code == intSqrt) begin
            assert (cycles > 1) else failTest("Square root finished in a single cycle");
        end else begin
            assert (cycles == 1) else failTest($sformatf(
                "Operation code %02h took %0d cycles instead of one", code, cycles));
        end
        assert (result === expected) else failTest($sformatf(
            "Mismatch result code=%02h opA=%08h opB=%08h got=%08h expected=%08h",
            code, a, b, result, expected));
        lastResult = expected;
    endtask

    initial begin
        int                   i;
        int                   index;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        seed         = 12160;
        Reset        = 1'b1;
        start        = 1'b0;
        operandA     = '0;
        operandB     = '0;
        functionCode = '0;
        lastResult   = '0;
        randomCodes  = '{intAdd, intSub, intMul, intDiv, intMod, shiftLeftArith,
                         shiftRightArith, cmpEqual, cmpNotEqual, cmpGreater, cmpLess,
                         cmpGreaterUnsigned, cmpLessUnsigned, logicNot, logicAnd, logicOr,
                         logicXor, logicXnor, shiftLeftLogic, shiftRightLogic};
        repeat (16) @(posedge Clock);
        Reset <= 1'b0;
        @(negedge Clock);
        assert (done === 1'b1) else failTest("done is not high after reset");
        assert (result === '0) else failTest($sformatf(
            "Mismatch result after reset got=%08h expected=%08h", result, 0));

        // Division corners
        runOp(intDiv, 32'd12345, 32'd0, 1'b0);
        runOp(intMod, 32'd12345, 32'd0, 1'b0);
        runOp(intDiv, MinValue, '1, 1'b0);
        runOp(intMod, MinValue, '1, 1'b0);
        runOp(intDiv, -32'sd7, 32'd2, 1'b0);
        runOp(intMod, -32'sd7, 32'd2, 1'b0);

        // Float and unused codes
        runOp(6'b001110, 32'd5, 32'd6, 1'b0);
        runOp(6'b001111, 32'd5, 32'd6, 1'b0);
        runOp(6'b010101, 32'd5, 32'd6, 1'b0);
        runOp(6'b011000, 32'd5, 32'd6, 1'b0);
        for (i = 0; i < 10; i++) begin
            runOp({1'b1, 5'($random(seed))}, $random(seed), $random(seed), 1'b0);
        end

        runOp(intSqrt, 32'd0, 32'd0, 1'b0);
        runOp(intSqrt, 32'd1, 32'd0, 1'b0);
        runOp(intSqrt, 32'd2, 32'd0, 1'b0);
        runOp(intSqrt, 32'd144, 32'd0, 1'b0);
        runOp(intSqrt, 32'd1000000, 32'd0, 1'b0);
        runOp(intSqrt, 32'hFFFE_0001, 32'd0, 1'b0);
        runOp(intSqrt, 32'hFFFF_FFFF, 32'd0, 1'b0);
        for (i = 0; i < 20; i++) begin
            runOp(intSqrt, $random(seed), $random(seed), 1'b0);
        end

        // Ignored start during a square root and a normal operation after it
        runOp(intSqrt, 32'd999999, 32'd0, 1'b1);
        runOp(intAdd, 32'd40, 32'd2, 1'b0);

        for (i = 0; i < RandomOps; i++) begin
            index = $unsigned($random(seed)) % 20;
            a = $random(seed);
            b = $random(seed);
            case ($unsigned($random(seed)) % 8)
                0: b = a;
                1: b = $unsigned($random(seed)) % 16;
                default: ;
            endcase
            runOp(randomCodes[index], a, b, 1'b0);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu import aluPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 start,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic [5:0]           functionCode,
    output logic                 done,
    output logic [DataWidth-1:0] result
);

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    aluOpcode             opCode;
    logic [DataWidth-1:0] logicResult;
    logic [DataWidth-1:0] sqrtResult;
    logic                 sqrtStart;
    logic                 sqrtDone;

    aluSequencer #(.DataWidth(DataWidth)) i_aluSequencer (
        .Clock        (Clock),
        .Reset        (Reset),
        .start        (start),
        .operandA     (operandA),
        .operandB     (operandB),
        .functionCode (functionCode),
        .logicResult  (logicResult),
        .sqrtResult   (sqrtResult),
        .sqrtDone     (sqrtDone),
        .opA          (opA),
        .opB          (opB),
        .opCode       (opCode),
        .sqrtStart    (sqrtStart),
        .done         (done),
        .result       (result)
    );

    // Both units see the same captured operands
    integerLogicUnit #(.DataWidth(DataWidth)) i_integerLogicUnit (
        .opA         (opA),
        .opB         (opB),
        .opCode      (opCode),
        .logicResult (logicResult)
    );

    intSqrtUnit #(.DataWidth(DataWidth)) i_intSqrtUnit (
        .Clock      (Clock),
        .Reset      (Reset),
        .sqrtStart  (sqrtStart),
        .radicand   (opA),
        .sqrtResult (sqrtResult),
        .sqrtDone   (sqrtDone)
    );

endmodule

`default_nettype wire

// File: aluSequencer.sv
`default_nettype none

module aluSequencer import aluPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 start,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic [5:0]           functionCode,
    input  logic [DataWidth-1:0] logicResult,
    input  logic [DataWidth-1:0] sqrtResult,
    input  logic                 sqrtDone,
    output logic [DataWidth-1:0] opA,
    output logic [DataWidth-1:0] opB,
    output aluOpcode             opCode,
    output logic                 sqrtStart,
    output logic                 done,
    output logic [DataWidth-1:0] result
);

    sequencerState state;
    logic          codeValid;
    logic          accept;

    function automatic logic isKnownCode(input logic [5:0] code);
        logic known;
        case (code)
            intAdd, intSub, intMul, intSqrt, intDiv, intMod,
            shiftLeftArith, shiftRightArith,
            cmpEqual, cmpNotEqual, cmpGreater, cmpLess,
            cmpGreaterUnsigned, cmpLessUnsigned,
            logicNot, logicAnd, logicOr, logicXor, logicXnor,
            shiftLeftLogic, shiftRightLogic: known = 1'b1;
            default: known = 1'b0;
        endcase
        return known;
    endfunction

    // Start only counts while idle
    assign accept = start && (state == idle);

    always_ff @(posedge Clock) begin
        if (accept) begin
            opA       <= operandA;
            opB       <= operandB;
            opCode    <= aluOpcode'(functionCode);
            codeValid <= isKnownCode(functionCode);
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state     <= idle;
            done      <= 1'b1;
            sqrtStart <= 1'b0;
            result    <= '0;
        end else begin
            sqrtStart <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        state <= execute;
                        done  <= 1'b0;
                    end
                end
                execute: begin
                    if (opCode == intSqrt) begin
                        sqrtStart <= 1'b1;
                        state     <= waitSqrt;
                    end else begin
                        result <= codeValid ? logicResult : '0;
                        done   <= 1'b1;
                        state  <= idle;
                    end
                end
                waitSqrt: begin
                    // sqrtDone is still high in the cycle the pulse is out
                    if (sqrtDone && !sqrtStart) begin
                        result <= sqrtResult;
                        done   <= 1'b1;
                        state  <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assert property (@(posedge Clock) disable iff (Reset) done == (state == idle))
        else $error("done does not match the idle state");

    assert property (@(posedge Clock) disable iff (Reset) (state == idle) |-> sqrtDone)
        else $error("Square-root unit busy while the sequencer is idle");

endmodule

`default_nettype wire

// File: intSqrtUnit.sv
`default_nettype none

module intSqrtUnit import aluPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 sqrtStart,
    input  logic [DataWidth-1:0] radicand,
    output logic [DataWidth-1:0] sqrtResult,
    output logic                 sqrtDone
);

    localparam int Half = DataWidth / 2;
    localparam int CountWidth = $clog2(Half + 1);
    localparam logic [CountWidth-1:0] LastStep = CountWidth'(Half - 1);

    sqrtState              state;
    logic [CountWidth-1:0] count;
    logic [DataWidth-1:0]  operandShift;
    logic [Half+1:0]       remainder;
    logic [Half-1:0]       root;
    logic [Half+1:0]       partial;
    logic [Half+1:0]       trial;

    // Bring down the next two radicand bits
    assign partial = {remainder[Half-1:0], operandShift[DataWidth-1 -: 2]};
    assign trial   = {root, 2'b01};

    always_ff @(posedge Clock) begin
        if (sqrtStart && state == sqrtIdle) begin
            operandShift <= radicand;
            remainder    <= '0;
            root         <= '0;
        end else if (state == sqrtRun) begin
            operandShift <= operandShift << 2;
            if (partial >= trial) begin
                remainder <= partial - trial;
                root      <= {root[Half-2:0], 1'b1};
            end else begin
                remainder <= partial;
                root      <= {root[Half-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= sqrtIdle;
            count <= '0;
        end else begin
            case (state)
                sqrtIdle: begin
                    if (sqrtStart) begin
                        state <= sqrtRun;
                        count <= '0;
                    end
                end
                sqrtRun: begin
                    count <= count + 1'b1;
                    if (count == LastStep) begin
                        state <= sqrtIdle;
                    end
                end
                default: state <= sqrtIdle;
            endcase
        end
    end

    assign sqrtResult = {{(DataWidth - Half){1'b0}}, root};
    assign sqrtDone   = (state == sqrtIdle);

    assert property (@(posedge Clock) disable iff (Reset) sqrtStart |-> state == sqrtIdle)
        else $error("sqrtStart arrived while the square root was running");

    assert property (@(posedge Clock) disable iff (Reset) count <= CountWidth'(Half))
        else $error("Square-root step counter ran past its last step");

endmodule

`default_nettype wire

// File: integerLogicUnit.sv
`default_nettype none

module integerLogicUnit import aluPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    input  aluOpcode             opCode,
    output logic [DataWidth-1:0] logicResult
);

    localparam int ShiftBits = $clog2(DataWidth);
    localparam logic [DataWidth-1:0] MostNegative = {1'b1, {(DataWidth - 1){1'b0}}};

    logic signed [DataWidth-1:0] signedA;
    logic signed [DataWidth-1:0] signedB;
    logic signed [DataWidth-1:0] quotient;
    logic signed [DataWidth-1:0] remainder;
    logic [ShiftBits-1:0]        shiftAmount;
    logic                        divByZero;
    logic                        divOverflow;

    assign signedA     = opA;
    assign signedB     = opB;
    assign shiftAmount = opB[ShiftBits-1:0];
    assign divByZero   = (opB == '0);
    assign divOverflow = (opA == MostNegative) && (opB == '1);

    // Division with the two corner cases pinned down
    always_comb begin
        if (divByZero) begin
            quotient  = '1;
            remainder = signedA;
        end else if (divOverflow) begin
            quotient  = signedA;
            remainder = '0;
        end else begin
            quotient  = signedA / signedB;
            remainder = signedA % signedB;
        end
    end

    always_comb begin
        case (opCode)
            intAdd:             logicResult = signedA + signedB;
            intSub:             logicResult = signedA - signedB;
            intMul:             logicResult = signedA * signedB;
            intDiv:             logicResult = quotient;
            intMod:             logicResult = remainder;
            shiftLeftArith:     logicResult = opA << shiftAmount;
            shiftRightArith:    logicResult = signedA >>> shiftAmount;
            cmpEqual: begin
                logicResult = {{(DataWidth - 1){1'b0}}, opA == opB};
            end
            cmpNotEqual: begin
                logicResult = {{(DataWidth - 1){1'b0}}, opA != opB};
            end
            cmpGreater: begin
                logicResult = {{(DataWidth - 1){1'b0}}, signedA > signedB};
            end
            cmpLess: begin
                logicResult = {{(DataWidth - 1){1'b0}}, signedA < signedB};
            end
            cmpGreaterUnsigned: begin
                logicResult = {{(DataWidth - 1){1'b0}}, opA > opB};
            end
            cmpLessUnsigned: begin
                logicResult = {{(DataWidth - 1){1'b0}}, opA < opB};
            end
            logicNot:           logicResult = ~opA;
            logicAnd:           logicResult = opA & opB;
            logicOr:            logicResult = opA | opB;
            logicXor:           logicResult = opA ^ opB;
            logicXnor:          logicResult = opA ~^ opB;
            shiftLeftLogic:     logicResult = opA << shiftAmount;
            shiftRightLogic:    logicResult = opA >> shiftAmount;
            // intSqrt is served by the square-root unit
            default:            logicResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: aluPkg.sv
`default_nettype none

package aluPkg;

    // Function codes as decoded by the core
    typedef enum logic [5:0] {
        intAdd             = 6'b000000,
        intSub             = 6'b000001,
        intMul             = 6'b000010,
        intSqrt            = 6'b000011,
        intDiv             = 6'b000100,
        intMod             = 6'b000101,
        shiftLeftArith     = 6'b000110,
        shiftRightArith    = 6'b000111,
        // Compares with a one-bit result
        cmpEqual           = 6'b001000,
        cmpNotEqual        = 6'b001001,
        cmpGreater         = 6'b001010,
        cmpLess            = 6'b001011,
        cmpGreaterUnsigned = 6'b001100,
        cmpLessUnsigned    = 6'b001101,
        // Bitwise logic and logical shifts
        logicNot           = 6'b010000,
        logicAnd           = 6'b010001,
        logicOr            = 6'b010010,
        logicXor           = 6'b010011,
        logicXnor          = 6'b010100,
        shiftLeftLogic     = 6'b010110,
        shiftRightLogic    = 6'b010111
    } aluOpcode;

    typedef enum logic [1:0] {
        idle,
        execute,
        waitSqrt
    } sequencerState;

    typedef enum logic {
        sqrtIdle,
        sqrtRun
    } sqrtState;

endpackage

`default_nettype wire
